// File: tb.f
design/qproc_pkg.sv
design/qproc_ctrl_fsm.sv
design/qproc_time_base.sv
design/qproc_credit_cnt.sv
design/qproc_mem.sv
design/qproc_mem_dma.sv
design/qproc_top.sv
testbench/qproc_sva.sv
testbench/tb_qproc.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_qproc
FILELIST ?= tb.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail on SIMULATION FAILED"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_qproc.sv
/*
 * Testbench for qproc_top. Random control pulses, time commands and
 * stream transfers from an LFSR, checked against a model of the state,
 * the time and the three memories.
 */

module tb_qproc;

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED      = 32'hf5f0_8733;
   localparam int          N_XFER    = 60;
   // Worst case cycles for one transfer of 256 words with slow credits
   localparam int          XFER_CYC  = 256 * 64;

   logic                          c_clk = 1'b0;
   logic                          rst_n_i;
   logic                          proc_run_i;
   logic                          proc_pause_i;
   logic                          proc_stop_i;
   logic                          time_rst_i;
   logic                          time_init_i;
   logic                          time_updt_i;
   logic [qproc_pkg::TIME_W-1:0]  offset_dt_i;
   qproc_pkg::core_state_t        core_state_o;
   logic [qproc_pkg::TIME_W-1:0]  t_time_abs_o;
   qproc_pkg::mem_cfg_t           mem_cfg_i;
   logic                          mem_start_i;
   logic                          mem_busy_o;
   logic                          s_valid_i;
   qproc_pkg::dma_word_t          s_word_i;
   logic                          s_credit_o;
   logic                          m_credit_i;
   logic                          m_valid_o;
   qproc_pkg::dma_word_t          m_word_o;

   logic [31:0]                   lfsr_q;
   qproc_pkg::core_state_t        exp_state;
   logic [qproc_pkg::TIME_W-1:0]  exp_time;
   qproc_pkg::pmem_word_t         pm [256];
   qproc_pkg::dmem_word_t         dm [16];
   qproc_pkg::wmem_word_t         wm [16];
   qproc_pkg::dma_word_t          exp_q [$];
   int                            src_cred = 0;
   int                            sink_cred = 0;
   int                            granted = 0;
   logic                          busy_s = 1'b0;
   logic                          gap_mode = 1'b0;
   logic                          last_sent = 1'b0;

   qproc_top i_dut (.*);

   always #2 c_clk = ~c_clk;

   //////////////////////////////
   // Helpers
   //////////////////////////////
   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rnd(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic logic [qproc_pkg::DMA_W-1:0] rnd_data();
      logic [qproc_pkg::DMA_W-1:0] d;
      for (int i = 0; i < qproc_pkg::DMA_W / 32; i++) begin
         d[i*32 +: 32] = rnd(32);
      end
      return d;
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   // Random control pulses and time commands, overlaps allowed
   task automatic drive_control();
      proc_run_i   <= (rnd(2) == 0);
      proc_pause_i <= (rnd(3) == 0);
      proc_stop_i  <= (rnd(3) == 0);
      time_rst_i   <= (rnd(5) == 0);
      time_init_i  <= (rnd(4) == 0);
      time_updt_i  <= (rnd(4) == 0);
      offset_dt_i  <= {16'(rnd(16)), rnd(32)};
   endtask

   // One clock step; pulses drop unless the caller drives them again
   task automatic tick();
      @(posedge c_clk);
      drive_control();
      mem_start_i <= 1'b0;
      s_valid_i   <= 1'b0;
      m_credit_i  <= 1'b0;
      if (sink_cred < qproc_pkg::DMA_CREDITS &&
          (gap_mode ? (rnd(4) == 0) : (rnd(1) == 1))) begin
         m_credit_i <= 1'b1;
         sink_cred++;
      end
   endtask

   task automatic start_xfer(input qproc_pkg::mem_cfg_t cfg);
      tick();
      mem_cfg_i   <= cfg;
      mem_start_i <= 1'b1;
      granted = 0;
      tick();
   endtask

   task automatic wait_idle();
      do begin
         tick();
      end while (busy_s);
   endtask

   task automatic do_write(input qproc_pkg::mem_cfg_t cfg);
      int                   n;
      int                   k;
      int                   ignore_at;
      logic [15:0]          a;
      qproc_pkg::dma_word_t w;
      qproc_pkg::mem_cfg_t  junk;
      n = int'(cfg.len) + 1;
      k = 0;
      ignore_at = rnd(3);
      start_xfer(cfg);
      while (k < n) begin
         tick();
         // Second start while busy must be ignored
         if (k == ignore_at) begin
            junk = qproc_pkg::mem_cfg_t'({3'(rnd(3)), rnd(32)});
            mem_cfg_i   <= junk;
            mem_start_i <= 1'b1;
         end
         if (src_cred > 0 && rnd(1) == 1) begin
            w.data = rnd_data();
            w.last = 1'(rnd(1));
            s_valid_i <= 1'b1;
            s_word_i  <= w;
            a = cfg.start_addr + 16'(k);
            case (cfg.mem_sel)
               qproc_pkg::MEM_PMEM: pm[a[7:0]] = w.data[71:0];
               qproc_pkg::MEM_DMEM: dm[a[3:0]] = w.data[31:0];
               qproc_pkg::MEM_WMEM: wm[a[3:0]] = w.data[167:0];
               default: ;
            endcase
            src_cred--;
            k++;
         end
      end
      // Last word is written on the next edge and busy drops one cycle later
      tick();
      assert (busy_s) else
         fail_now($sformatf("mismatch t=%0t mem_busy_o exp=1 got=0", $time));
      tick();
      assert (!busy_s) else
         fail_now($sformatf("mismatch t=%0t mem_busy_o exp=0 got=1", $time));
      assert (granted == n) else
         fail_now($sformatf("mismatch t=%0t s_credit_o count exp=%0d got=%0d",
                            $time, n, granted));
   endtask

   task automatic do_read(input qproc_pkg::mem_cfg_t cfg);
      logic [15:0]          a;
      qproc_pkg::dma_word_t w;
      for (int k = 0; k <= int'(cfg.len); k++) begin
         a = cfg.start_addr + 16'(k);
         w = '0;
         case (cfg.mem_sel)
            qproc_pkg::MEM_PMEM: w.data[71:0]  = pm[a[7:0]];
            qproc_pkg::MEM_DMEM: w.data[31:0]  = dm[a[3:0]];
            qproc_pkg::MEM_WMEM: w.data[167:0] = wm[a[3:0]];
            default: ;
         endcase
         w.last = (k == int'(cfg.len));
         exp_q.push_back(w);
      end
      start_xfer(cfg);
      wait_idle();
      assert (exp_q.size() == 0) else
         fail_now($sformatf("read ended with %0d words not received", exp_q.size()));
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   task automatic run_dma();
      qproc_pkg::mem_cfg_t cfg;
      // Full-depth fill of each memory first
      for (int s = 1; s < 4; s++) begin
         cfg.mem_sel    = qproc_pkg::mem_sel_t'(s);
         cfg.wr         = 1'b1;
         cfg.start_addr = '0;
         cfg.len        = (s == 1) ? 16'd255 : 16'd15;
         do_write(cfg);
      end
      for (int t = 0; t < N_XFER; t++) begin
         cfg.mem_sel    = qproc_pkg::mem_sel_t'(2'(rnd(2)));
         cfg.wr         = 1'(rnd(1));
         cfg.start_addr = 16'(rnd(16));
         cfg.len        = 16'(rnd(6));
         gap_mode = (rnd(2) == 0);
         if (cfg.wr) begin
            do_write(cfg);
         end else begin
            do_read(cfg);
         end
      end
   endtask

   //////////////////////////////
   // Model and checks
   //////////////////////////////
   always @(posedge c_clk) begin
      if (!rst_n_i) begin
         exp_state = qproc_pkg::ST_STOP;
         exp_time  = '0;
      end else begin
         if (time_rst_i) exp_time = '0;
         else if (time_init_i) exp_time = offset_dt_i;
         else if (time_updt_i) exp_time = exp_time + offset_dt_i;
         else if (exp_state != qproc_pkg::ST_STOP) exp_time = exp_time + 1'b1;
         if (proc_stop_i) exp_state = qproc_pkg::ST_STOP;
         else if (proc_pause_i) exp_state = qproc_pkg::ST_PAUSE;
         else if (proc_run_i) exp_state = qproc_pkg::ST_RUN;
      end
   end

   always @(negedge c_clk) begin
      qproc_pkg::dma_word_t w;
      busy_s = mem_busy_o;
      if (s_credit_o) begin
         src_cred++;
         granted++;
      end
      assert (core_state_o == exp_state) else
         fail_now($sformatf("mismatch t=%0t core_state_o exp=%0d got=%0d",
                            $time, exp_state, core_state_o));
      assert (t_time_abs_o == exp_time) else
         fail_now($sformatf("mismatch t=%0t t_time_abs_o exp=%0h got=%0h",
                            $time, exp_time, t_time_abs_o));
      // Busy drops on the cycle after the word with last
      assert (!(last_sent && mem_busy_o)) else
         fail_now($sformatf("mismatch t=%0t mem_busy_o exp=0 got=1", $time));
      last_sent = m_valid_o && m_word_o.last;
      if (m_valid_o) begin
         assert (sink_cred > 0) else fail_now("output word sent without a sink credit");
         assert (exp_q.size() > 0) else fail_now("output word sent with no read pending");
         w = exp_q.pop_front();
         assert (m_word_o == w) else
            fail_now($sformatf("mismatch t=%0t m_word_o exp=%h got=%h", $time, w, m_word_o));
         sink_cred--;
      end
   end

   // Watchdog
   initial begin
      #(4.0 * XFER_CYC * (N_XFER + 3));
      fail_now("watchdog timeout, transfers did not complete");
   end

   initial begin
      lfsr_q       = SEED;
      rst_n_i      = 1'b0;
      proc_run_i   = 1'b0;
      proc_pause_i = 1'b0;
      proc_stop_i  = 1'b0;
      time_rst_i   = 1'b0;
      time_init_i  = 1'b0;
      time_updt_i  = 1'b0;
      offset_dt_i  = '0;
      mem_cfg_i    = '0;
      mem_start_i  = 1'b0;
      s_valid_i    = 1'b0;
      s_word_i     = '0;
      m_credit_i   = 1'b0;
      repeat (4) @(posedge c_clk);
      rst_n_i <= 1'b1;
      run_dma();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: testbench/qproc_sva.sv
/*
 * Stream credit assertions for the memory stream engine.
 * Credits are counted from the port handshakes and bound into
 * every qproc_mem_dma instance.
 */

module qproc_sva (
   input logic   c_clk,
   input logic   rst_n_i,
   input logic   busy_i,
   input logic   s_credit_i,
   input logic   s_valid_i,
   input logic   m_credit_i,
   input logic   m_valid_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // Input credits granted but not yet used by the source
   int in_open_q;
   // Sink credits received but not yet answered with a word
   int out_held_q;

   always_ff @(posedge c_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         in_open_q  <= 0;
         out_held_q <= 0;
      end else begin
         in_open_q  <= in_open_q + int'(s_credit_i) - int'(s_valid_i);
         out_held_q <= out_held_q + int'(m_credit_i) - int'(m_valid_i);
      end
   end

   // Outstanding input credits stay within the limit
   a_in_cred_max: assert property (@(posedge c_clk) disable iff (!rst_n_i)
      in_open_q <= qproc_pkg::DMA_CREDITS)
      else $error("input credits above limit");

   // Each output word was paid for by a held sink credit
   a_out_paid: assert property (@(posedge c_clk) disable iff (!rst_n_i)
      m_valid_i |-> out_held_q > 0)
      else $error("output word without a held credit");

   // Idle engine grants nothing and has no input credit left open
   a_idle_quiet: assert property (@(posedge c_clk) disable iff (!rst_n_i)
      !busy_i |-> (!s_credit_i && in_open_q == 0))
      else $error("input credit open or granted while idle");

endmodule

bind qproc_mem_dma qproc_sva i_sva (
   .c_clk      (c_clk),
   .rst_n_i    (rst_n_i),
   .busy_i     (busy_q),
   .s_credit_i (s_credit_o),
   .s_valid_i  (s_valid_i),
   .m_credit_i (m_credit_i),
   .m_valid_i  (m_valid_o)
);

// File: design/qproc_top.sv
/*
 * Top level of the control and memory-load block.
 * Joins the processor state machine, the time base, the stream
 * engine and the program, data and wave memories on c_clk.
 */

module qproc_top (
   input  logic                             c_clk,
   input  logic                             rst_n_i,
   // Processor and time control
   input  logic                             proc_run_i,
   input  logic                             proc_pause_i,
   input  logic                             proc_stop_i,
   input  logic                             time_rst_i,
   input  logic                             time_init_i,
   input  logic                             time_updt_i,
   input  logic [qproc_pkg::TIME_W-1:0]     offset_dt_i,
   output qproc_pkg::core_state_t           core_state_o,
   output logic [qproc_pkg::TIME_W-1:0]     t_time_abs_o,
   // Transfer configuration
   input  qproc_pkg::mem_cfg_t              mem_cfg_i,
   input  logic                             mem_start_i,
   output logic                             mem_busy_o,
   // Streams
   input  logic                             s_valid_i,
   input  qproc_pkg::dma_word_t             s_word_i,
   output logic                             s_credit_o,
   input  logic                             m_credit_i,
   output logic                             m_valid_o,
   output qproc_pkg::dma_word_t             m_word_o
);

   logic                            time_en;
   logic                            pmem_we;
   logic [qproc_pkg::PMEM_AW-1:0]   pmem_addr;
   qproc_pkg::pmem_word_t           pmem_wdata;
   qproc_pkg::pmem_word_t           pmem_rdata;
   logic                            dmem_we;
   logic [qproc_pkg::DMEM_AW-1:0]   dmem_addr;
   qproc_pkg::dmem_word_t           dmem_wdata;
   qproc_pkg::dmem_word_t           dmem_rdata;
   logic                            wmem_we;
   logic [qproc_pkg::WMEM_AW-1:0]   wmem_addr;
   qproc_pkg::wmem_word_t           wmem_wdata;
   qproc_pkg::wmem_word_t           wmem_rdata;

   qproc_ctrl_fsm i_fsm (
      .c_clk        (c_clk),
      .rst_n_i      (rst_n_i),
      .proc_run_i   (proc_run_i),
      .proc_pause_i (proc_pause_i),
      .proc_stop_i  (proc_stop_i),
      .core_state_o (core_state_o),
      .time_en_o    (time_en)
   );

   qproc_time_base i_time (
      .c_clk        (c_clk),
      .rst_n_i      (rst_n_i),
      .time_en_i    (time_en),
      .time_rst_i   (time_rst_i),
      .time_init_i  (time_init_i),
      .time_updt_i  (time_updt_i),
      .offset_dt_i  (offset_dt_i),
      .t_time_abs_o (t_time_abs_o)
   );

   qproc_mem_dma i_dma (
      .c_clk        (c_clk),
      .rst_n_i      (rst_n_i),
      .mem_cfg_i    (mem_cfg_i),
      .mem_start_i  (mem_start_i),
      .mem_busy_o   (mem_busy_o),
      .s_valid_i    (s_valid_i),
      .s_word_i     (s_word_i),
      .s_credit_o   (s_credit_o),
      .m_credit_i   (m_credit_i),
      .m_valid_o    (m_valid_o),
      .m_word_o     (m_word_o),
      .pmem_we_o    (pmem_we),
      .pmem_addr_o  (pmem_addr),
      .pmem_wdata_o (pmem_wdata),
      .pmem_rdata_i (pmem_rdata),
      .dmem_we_o    (dmem_we),
      .dmem_addr_o  (dmem_addr),
      .dmem_wdata_o (dmem_wdata),
      .dmem_rdata_i (dmem_rdata),
      .wmem_we_o    (wmem_we),
      .wmem_addr_o  (wmem_addr),
      .wmem_wdata_o (wmem_wdata),
      .wmem_rdata_i (wmem_rdata)
   );

   //////////////////////////////
   // Memories
   //////////////////////////////
   qproc_mem #(.word_t(qproc_pkg::pmem_word_t), .AW(qproc_pkg::PMEM_AW)) i_pmem (
      .c_clk   (c_clk),
      .we_i    (pmem_we),
      .addr_i  (pmem_addr),
      .wdata_i (pmem_wdata),
      .rdata_o (pmem_rdata)
   );

   qproc_mem #(.word_t(qproc_pkg::dmem_word_t), .AW(qproc_pkg::DMEM_AW)) i_dmem (
      .c_clk   (c_clk),
      .we_i    (dmem_we),
      .addr_i  (dmem_addr),
      .wdata_i (dmem_wdata),
      .rdata_o (dmem_rdata)
   );

   qproc_mem #(.word_t(qproc_pkg::wmem_word_t), .AW(qproc_pkg::WMEM_AW)) i_wmem (
      .c_clk   (c_clk),
      .we_i    (wmem_we),
      .addr_i  (wmem_addr),
      .wdata_i (wmem_wdata),
      .rdata_o (wmem_rdata)
   );

endmodule

// File: design/qproc_mem_dma.sv
/*
 * Stream engine for loading and reading back the three memories.
 * A start pulse latches the configuration; the engine then grants input
 * credits and writes arriving words, or spends output credits on reads.
 */

module qproc_mem_dma (
   input  logic                                c_clk,
   input  logic                                rst_n_i,
   input  qproc_pkg::mem_cfg_t                 mem_cfg_i,
   input  logic                                mem_start_i,
   output logic                                mem_busy_o,
   // Input stream
   input  logic                                s_valid_i,
   input  qproc_pkg::dma_word_t                s_word_i,
   output logic                                s_credit_o,
   // Output stream
   input  logic                                m_credit_i,
   output logic                                m_valid_o,
   output qproc_pkg::dma_word_t                m_word_o,
   // Memories
   output logic                                pmem_we_o,
   output logic [qproc_pkg::PMEM_AW-1:0]       pmem_addr_o,
   output qproc_pkg::pmem_word_t               pmem_wdata_o,
   input  qproc_pkg::pmem_word_t               pmem_rdata_i,
   output logic                                dmem_we_o,
   output logic [qproc_pkg::DMEM_AW-1:0]       dmem_addr_o,
   output qproc_pkg::dmem_word_t               dmem_wdata_o,
   input  qproc_pkg::dmem_word_t               dmem_rdata_i,
   output logic                                wmem_we_o,
   output logic [qproc_pkg::WMEM_AW-1:0]       wmem_addr_o,
   output qproc_pkg::wmem_word_t               wmem_wdata_o,
   input  qproc_pkg::wmem_word_t               wmem_rdata_i
);

   localparam int CNT_W = qproc_pkg::LEN_W + 1;

   qproc_pkg::mem_cfg_t             cfg_q;
   logic                            busy_q;
   logic [qproc_pkg::LEN_W-1:0]     addr_q;
   // Words still to move, and input credits still to grant
   logic [CNT_W-1:0]                remain_q;
   logic [CNT_W-1:0]                grant_left_q;
   logic [qproc_pkg::CRED_W-1:0]    in_cred;
   logic [qproc_pkg::CRED_W-1:0]    out_cred;
   logic                            start;
   logic                            wr_word;
   logic                            rd_issue;
   logic                            rd_vld_q;
   logic                            rd_last_q;
   logic                            step;
   logic [qproc_pkg::DMA_W-1:0]     rd_data;

   assign start    = mem_start_i && !busy_q;
   assign wr_word  = busy_q && cfg_q.wr && s_valid_i && (remain_q != '0);
   assign rd_issue = busy_q && !cfg_q.wr && (remain_q != '0) && (out_cred != '0);
   assign step     = wr_word || rd_issue;

   // Grant only while credits are free and words are still unclaimed
   assign s_credit_o = busy_q && cfg_q.wr && (grant_left_q != '0) &&
                       (in_cred < qproc_pkg::CRED_W'(qproc_pkg::DMA_CREDITS));

   //////////////////////////////
   // Credit tracking
   //////////////////////////////
   qproc_credit_cnt i_in_cred (
      .c_clk   (c_clk),
      .rst_n_i (rst_n_i),
      .grant_i (s_credit_o),
      .use_i   (wr_word),
      .avail_o (in_cred)
   );

   // Sink credits may arrive at any time and are kept across transfers
   qproc_credit_cnt i_out_cred (
      .c_clk   (c_clk),
      .rst_n_i (rst_n_i),
      .grant_i (m_credit_i),
      .use_i   (rd_issue),
      .avail_o (out_cred)
   );

   //////////////////////////////
   // Transfer control
   //////////////////////////////
   always_ff @(posedge c_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q       <= 1'b0;
         remain_q     <= '0;
         grant_left_q <= '0;
         rd_vld_q     <= 1'b0;
         rd_last_q    <= 1'b0;
      end else begin
         rd_vld_q  <= rd_issue;
         rd_last_q <= rd_issue && (remain_q == CNT_W'(1));
         if (start) begin
            busy_q       <= 1'b1;
            remain_q     <= CNT_W'(mem_cfg_i.len) + 1'b1;
            grant_left_q <= CNT_W'(mem_cfg_i.len) + 1'b1;
         end else begin
            if (step) begin
               remain_q <= remain_q - 1'b1;
            end
            if (s_credit_o) begin
               grant_left_q <= grant_left_q - 1'b1;
            end
            // Write ends on the last word, read on the last word sent
            if ((wr_word && remain_q == CNT_W'(1)) || rd_last_q) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge c_clk) begin
      if (start) begin
         cfg_q  <= mem_cfg_i;
         addr_q <= mem_cfg_i.start_addr;
      end else if (step) begin
         addr_q <= addr_q + 1'b1;
      end
   end

   //////////////////////////////
   // Memory routing
   //////////////////////////////
   // Low address bits wrap at each memory's depth
   assign pmem_we_o    = wr_word && (cfg_q.mem_sel == qproc_pkg::MEM_PMEM);
   assign dmem_we_o    = wr_word && (cfg_q.mem_sel == qproc_pkg::MEM_DMEM);
   assign wmem_we_o    = wr_word && (cfg_q.mem_sel == qproc_pkg::MEM_WMEM);
   assign pmem_addr_o  = addr_q[qproc_pkg::PMEM_AW-1:0];
   assign dmem_addr_o  = addr_q[qproc_pkg::DMEM_AW-1:0];
   assign wmem_addr_o  = addr_q[qproc_pkg::WMEM_AW-1:0];
   assign pmem_wdata_o = s_word_i.data[$bits(qproc_pkg::pmem_word_t)-1:0];
   assign dmem_wdata_o = s_word_i.data[$bits(qproc_pkg::dmem_word_t)-1:0];
   assign wmem_wdata_o = s_word_i.data[$bits(qproc_pkg::wmem_word_t)-1:0];

   // Zero-extended read data, nothing for MEM_NONE
   always_comb begin
      rd_data = '0;
      case (cfg_q.mem_sel)
         qproc_pkg::MEM_PMEM: rd_data[$bits(qproc_pkg::pmem_word_t)-1:0] = pmem_rdata_i;
         qproc_pkg::MEM_DMEM: rd_data[$bits(qproc_pkg::dmem_word_t)-1:0] = dmem_rdata_i;
         qproc_pkg::MEM_WMEM: rd_data[$bits(qproc_pkg::wmem_word_t)-1:0] = wmem_rdata_i;
         default:             rd_data = '0;
      endcase
   end

   assign m_valid_o     = rd_vld_q;
   assign m_word_o.data = rd_data;
   assign m_word_o.last = rd_last_q;
   assign mem_busy_o    = busy_q;

endmodule

// File: design/qproc_mem.sv
/*
 * Single-port synchronous RAM, one cycle read latency.
 * Word type and address width are parameters, so one module
 * serves the program, data and wave memories.
 */

module qproc_mem #(
   parameter type word_t = logic [31:0],
   parameter int  AW     = 4
) (
   input  logic            c_clk,
   input  logic            we_i,
   input  logic [AW-1:0]   addr_i,
   input  word_t           wdata_i,
   output word_t           rdata_o
);

   word_t ram [2**AW];

   // Read returns the old word on a write to the same address
   always_ff @(posedge c_clk) begin
      if (we_i) begin
         ram[addr_i] <= wdata_i;
      end
      rdata_o <= ram[addr_i];
   end

endmodule

// File: design/qproc_credit_cnt.sv
/*
 * Stream credit counter, 0 to DMA_CREDITS.
 * One step up per grant and one step down per use, both in one cycle allowed.
 * Saturates at both ends.
 */

module qproc_credit_cnt (
   input  logic                           c_clk,
   input  logic                           rst_n_i,
   input  logic                           grant_i,
   input  logic                           use_i,
   output logic [qproc_pkg::CRED_W-1:0]   avail_o
);

   logic [qproc_pkg::CRED_W-1:0] cnt_q;
   logic                         full;
   logic                         empty;

   assign full  = (cnt_q == qproc_pkg::CRED_W'(qproc_pkg::DMA_CREDITS));
   assign empty = (cnt_q == '0);

   always_ff @(posedge c_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (grant_i && !use_i && !full) begin
         cnt_q <= cnt_q + 1'b1;
      end else if (use_i && !grant_i && !empty) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign avail_o = cnt_q;

endmodule

// File: design/qproc_time_base.sv
/*
 * Absolute time counter.
 * Reset, init from offset and add offset, in that priority;
 * otherwise counts one per cycle while enabled.
 */

module qproc_time_base (
   input  logic                             c_clk,
   input  logic                             rst_n_i,
   input  logic                             time_en_i,
   input  logic                             time_rst_i,
   input  logic                             time_init_i,
   input  logic                             time_updt_i,
   input  logic [qproc_pkg::TIME_W-1:0]     offset_dt_i,
   output logic [qproc_pkg::TIME_W-1:0]     t_time_abs_o
);

   logic [qproc_pkg::TIME_W-1:0] time_q;

   always_ff @(posedge c_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         time_q <= '0;
      end else if (time_rst_i) begin
         time_q <= '0;
      end else if (time_init_i) begin
         time_q <= offset_dt_i;
      end else if (time_updt_i) begin
         // Shift the running time by the offset
         time_q <= time_q + offset_dt_i;
      end else if (time_en_i) begin
         time_q <= time_q + 1'b1;
      end
   end

   assign t_time_abs_o = time_q;

endmodule

// File: design/qproc_ctrl_fsm.sv
/*
 * Processor state machine for stop, run and pause.
 * Control pulses take effect one cycle later, stop before pause before run.
 * Time keeps advancing in pause, since pause only holds the core.
 */

module qproc_ctrl_fsm (
   input  logic                       c_clk,
   input  logic                       rst_n_i,
   input  logic                       proc_run_i,
   input  logic                       proc_pause_i,
   input  logic                       proc_stop_i,
   output qproc_pkg::core_state_t     core_state_o,
   output logic                       time_en_o
);

   qproc_pkg::core_state_t state_q;
   qproc_pkg::core_state_t state_d;

   //////////////////////////////
   // Next state
   //////////////////////////////
   always_comb begin
      state_d = state_q;
      if (proc_stop_i) begin
         state_d = qproc_pkg::ST_STOP;
      end else if (proc_pause_i) begin
         state_d = qproc_pkg::ST_PAUSE;
      end else if (proc_run_i) begin
         state_d = qproc_pkg::ST_RUN;
      end
   end

   always_ff @(posedge c_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= qproc_pkg::ST_STOP;
      end else begin
         state_q <= state_d;
      end
   end

   assign core_state_o = state_q;

   // Time runs in any state but stop
   assign time_en_o = (state_q != qproc_pkg::ST_STOP);

endmodule

// File: design/qproc_pkg.sv
/*
 * Shared widths, memory word types, processor states and the
 * transfer configuration of the sequencer control block.
 * Every design and testbench file refers to these by qproc_pkg::name.
 */

package qproc_pkg;

   //////////////////////////////
   // Widths and depths
   //////////////////////////////
   localparam int TIME_W      = 48;
   localparam int DMA_W       = 256;
   localparam int DMA_CREDITS = 4;
   localparam int CRED_W      = $clog2(DMA_CREDITS + 1);
   localparam int PMEM_AW     = 8;
   localparam int DMEM_AW     = 4;
   localparam int WMEM_AW     = 4;
   // Address and length fields of a transfer
   localparam int LEN_W       = 16;

   // Memory words
   typedef logic [71:0]  pmem_word_t;
   typedef logic [31:0]  dmem_word_t;
   typedef logic [167:0] wmem_word_t;

   //////////////////////////////
   // Control encodings
   //////////////////////////////
   typedef enum logic [1:0] {
      ST_STOP  = 2'd0,
      ST_RUN   = 2'd1,
      ST_PAUSE = 2'd2
   } core_state_t;

   // Same numbering as the memory field of the original config register
   typedef enum logic [1:0] {
      MEM_NONE = 2'd0,
      MEM_PMEM = 2'd1,
      MEM_DMEM = 2'd2,
      MEM_WMEM = 2'd3
   } mem_sel_t;

   // A transfer moves len+1 words
   typedef struct packed {
      mem_sel_t           mem_sel;
      logic               wr;
      logic [LEN_W-1:0]   start_addr;
      logic [LEN_W-1:0]   len;
   } mem_cfg_t;

   typedef struct packed {
      logic [DMA_W-1:0]   data;
      logic               last;
   } dma_word_t;

endpackage
